/* tests/tb_cam_if_to_fifo.sv */
/* Small image (8x4) so each frame is short. Lock outputs and the overflow flag are
   polled on the falling clock edge, and stimulus changes on the rising edge. */

`timescale 1ns/1ps

module tb_cam_if_to_fifo
   import cam_timing_pkg::*;
   import fifo_word_pkg::*;
();

   localparam int IMG_HSIZE    = 8;
   localparam int IMG_VSIZE    = 4;
   localparam int FIFO_CREDITS = 6;
   localparam int FRAME_WORDS  = IMG_HSIZE * IMG_VSIZE;
   localparam int WAIT_LIMIT   = 400;
   localparam int CREDIT_DELAY = 3;
   // Status line selectors
   localparam int SEL_HLOCK = 0;
   localparam int SEL_FRAME = 1;
   localparam int SEL_OVF   = 2;

   logic                 CAM_pclk_in;
   logic                 rst;
   logic [CAM_BIT_W-1:0] cam_data;
   logic                 cam_hsync;
   logic                 cam_vsync;
   logic                 cam_de;
   logic                 cam_en;
   logic                 hsync_lock;
   logic                 frame_lock;
   logic                 fifo_wr_en;
   pixel_word_u          fifo_wr_data;
   logic                 fifo_credit;
   logic                 fifo_overflow;

   int          seed;
   int          err_value;
   int          err_other;
   int          wr_count;
   int          cycle_cnt;
   bit          credit_pause;
   logic        hlock_before_end;
   string       test_name;
   logic [15:0] exp_q[$];
   // Write times of entries still held by the FIFO model
   int          fifo_model_q[$];

   cam_if_to_fifo #(
      .IMG_HSIZE    (IMG_HSIZE),
      .IMG_VSIZE    (IMG_VSIZE),
      .FIFO_CREDITS (FIFO_CREDITS)
   ) DUT (
      .CAM_pclk_in   (CAM_pclk_in),
      .rst           (rst),
      .cam_data      (cam_data),
      .cam_hsync     (cam_hsync),
      .cam_vsync     (cam_vsync),
      .cam_de        (cam_de),
      .cam_en        (cam_en),
      .hsync_lock    (hsync_lock),
      .frame_lock    (frame_lock),
      .fifo_wr_en    (fifo_wr_en),
      .fifo_wr_data  (fifo_wr_data),
      .fifo_credit   (fifo_credit),
      .fifo_overflow (fifo_overflow)
   );

   initial begin
      CAM_pclk_in = 1'b0;
      forever #2 CAM_pclk_in = ~CAM_pclk_in;
   end

   // Expected FIFO word, even subpixel on top, upper 8 bits of each
   function automatic logic [15:0] pack_pair(input logic [CAM_BIT_W-1:0] even_sub,
                                             input logic [CAM_BIT_W-1:0] odd_sub);
      return {even_sub[CAM_BIT_W-1:CAM_BIT_W-8], odd_sub[CAM_BIT_W-1:CAM_BIT_W-8]};
   endfunction

   function automatic logic status_bit(input int sel);
      case (sel)
         SEL_HLOCK: return hsync_lock;
         SEL_FRAME: return frame_lock;
         default:   return fifo_overflow;
      endcase
   endfunction

   task automatic check_equal(input string what, input int exp, input int act);
      assert (exp == act) else begin
         err_value++;
         $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
                  test_name, what, exp, act);
      end
   endtask

   // Poll one status line until it reaches the wanted level
   task automatic wait_status(input int sel, input logic val, input string what);
      int   n;
      logic cur;
      n = 0;
      cur = status_bit(sel);
      while (cur !== val && n < WAIT_LIMIT) begin
         @(negedge CAM_pclk_in);
         cur = status_bit(sel);
         n++;
      end
      assert (cur === val) else begin
         err_other++;
         $display("%s: timed out after %0d cycles waiting for %s", test_name, n, what);
      end
   endtask

   // All expected words written and all credits back
   task automatic drain_fifo();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || fifo_model_q.size() != 0) && n < WAIT_LIMIT) begin
         @(negedge CAM_pclk_in);
         n++;
      end
      assert (exp_q.size() == 0 && fifo_model_q.size() == 0) else begin
         err_other++;
         $display("%s: timed out with %0d expected words unwritten and %0d credits held",
                  test_name, exp_q.size(), fifo_model_q.size());
      end
   endtask

   // One frame, lines of de bursts each followed by an hsync pulse
   // Only the first n_expect words are queued as expected writes
   task automatic send_frame(input int n_lines, input int short_line, input int n_expect,
                             input bit drop_en);
      int                   n_sub;
      int                   pushed;
      int                   line_idx;
      int                   sub_idx;
      logic [CAM_BIT_W-1:0] sub_val;
      logic [CAM_BIT_W-1:0] even_val;
      pushed = 0;
      even_val = '0;
      wr_count = 0;
      @(posedge CAM_pclk_in);
      cam_vsync <= 1'b1;
      repeat (3) @(posedge CAM_pclk_in);
      if (drop_en) begin
         cam_en <= 1'b0;
      end
      for (line_idx = 0; line_idx < n_lines; line_idx++) begin
         n_sub = (line_idx == short_line) ? 2 * IMG_HSIZE - 2 : 2 * IMG_HSIZE;
         for (sub_idx = 0; sub_idx < n_sub; sub_idx++) begin
            @(posedge CAM_pclk_in);
            sub_val = CAM_BIT_W'($random(seed));
            cam_de   <= 1'b1;
            cam_data <= sub_val;
            if (sub_idx % 2 == 0) begin
               even_val = sub_val;
            end else if (pushed < n_expect) begin
               exp_q.push_back(pack_pair(even_val, sub_val));
               pushed++;
            end
         end
         @(posedge CAM_pclk_in);
         cam_de   <= 1'b0;
         cam_data <= '0;
         @(posedge CAM_pclk_in);
         cam_hsync <= 1'b1;
         @(posedge CAM_pclk_in);
         cam_hsync <= 1'b0;
         repeat (3) @(posedge CAM_pclk_in);
         // Enable comes back after the first line
         if (drop_en && line_idx == 0) begin
            cam_en <= 1'b1;
         end
      end
      repeat (4) @(posedge CAM_pclk_in);
      @(negedge CAM_pclk_in);
      hlock_before_end = hsync_lock;
      @(posedge CAM_pclk_in);
      cam_vsync <= 1'b0;
      repeat (8) @(posedge CAM_pclk_in);
   endtask

   // FIFO model, frees each entry CREDIT_DELAY cycles after its write
   always @(posedge CAM_pclk_in) begin
      if (rst) begin
         fifo_credit <= 1'b0;
         fifo_model_q.delete();
      end else begin
         if (fifo_wr_en) begin
            fifo_model_q.push_back(cycle_cnt);
         end
         if (!credit_pause && fifo_model_q.size() > 0 &&
             cycle_cnt - fifo_model_q[0] >= CREDIT_DELAY) begin
            void'(fifo_model_q.pop_front());
            fifo_credit <= 1'b1;
         end else begin
            fifo_credit <= 1'b0;
         end
      end
      cycle_cnt++;
   end

   // Every write must match the next expected word
   always @(posedge CAM_pclk_in) begin : compare_writes
      logic [15:0] exp_word;
      if (!rst && fifo_wr_en) begin
         wr_count++;
         assert (exp_q.size() != 0) else begin
            err_other++;
            $display("%s: FIFO write of 0x%h with no word expected",
                     test_name, fifo_wr_data.word);
         end
         if (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            check_equal("FIFO word", exp_word, fifo_wr_data.word);
         end
      end
   end

   initial begin
      seed = 32'h7c220ff9;
      err_value = 0;
      err_other = 0;
      wr_count = 0;
      cycle_cnt = 0;
      credit_pause = 1'b0;
      test_name = "reset";
      rst = 1'b1;
      cam_data = '0;
      cam_hsync = 1'b0;
      cam_vsync = 1'b0;
      cam_de = 1'b0;
      cam_en = 1'b1;
      fifo_credit = 1'b0;
      repeat (10) @(posedge CAM_pclk_in);
      rst <= 1'b0;
      @(negedge CAM_pclk_in);
      check_equal("hsync_lock", 0, hsync_lock);
      check_equal("frame_lock", 0, frame_lock);
      check_equal("fifo_wr_en", 0, fifo_wr_en);
      check_equal("fifo_overflow", 0, fifo_overflow);

      // First good frame locks but writes nothing
      test_name = "first_frame";
      send_frame(IMG_VSIZE, -1, 0, 1'b0);
      wait_status(SEL_FRAME, 1'b1, "frame_lock high");
      drain_fifo();
      check_equal("write count", 0, wr_count);

      test_name = "locked_frame";
      send_frame(IMG_VSIZE, -1, FRAME_WORDS, 1'b0);
      drain_fifo();
      check_equal("write count", FRAME_WORDS, wr_count);
      check_equal("hsync_lock", 1, hlock_before_end);

      // Short line 0, its words still go out before the line end
      test_name = "short_line";
      send_frame(IMG_VSIZE, 0, IMG_HSIZE - 1, 1'b0);
      check_equal("hsync_lock", 0, hlock_before_end);
      wait_status(SEL_FRAME, 1'b0, "frame_lock low");
      drain_fifo();
      check_equal("write count", IMG_HSIZE - 1, wr_count);

      test_name = "after_short_line";
      send_frame(IMG_VSIZE, -1, 0, 1'b0);
      wait_status(SEL_FRAME, 1'b1, "frame_lock high");
      drain_fifo();
      check_equal("write count", 0, wr_count);

      // Still locked during the frame, so all its lines are written
      test_name = "missing_line";
      send_frame(IMG_VSIZE - 1, -1, (IMG_VSIZE - 1) * IMG_HSIZE, 1'b0);
      wait_status(SEL_FRAME, 1'b0, "frame_lock low");
      drain_fifo();
      check_equal("write count", (IMG_VSIZE - 1) * IMG_HSIZE, wr_count);

      test_name = "relock";
      send_frame(IMG_VSIZE, -1, 0, 1'b0);
      wait_status(SEL_FRAME, 1'b1, "frame_lock high");
      drain_fifo();
      check_equal("write count", 0, wr_count);

      test_name = "credit_pause";
      credit_pause = 1'b1;
      send_frame(IMG_VSIZE, -1, FIFO_CREDITS, 1'b0);
      wait_status(SEL_OVF, 1'b1, "fifo_overflow high");
      credit_pause = 1'b0;
      drain_fifo();
      check_equal("write count", FIFO_CREDITS, wr_count);

      test_name = "enable_drop";
      send_frame(IMG_VSIZE, -1, 0, 1'b1);
      check_equal("hsync_lock", 0, hlock_before_end);
      wait_status(SEL_FRAME, 1'b0, "frame_lock low");
      drain_fifo();
      check_equal("write count", 0, wr_count);

      test_name = "enable_restored";
      send_frame(IMG_VSIZE, -1, 0, 1'b0);
      wait_status(SEL_FRAME, 1'b1, "frame_lock high");
      drain_fifo();
      check_equal("write count", 0, wr_count);

      test_name = "writes_resume";
      send_frame(IMG_VSIZE, -1, FRAME_WORDS, 1'b0);
      drain_fifo();
      check_equal("write count", FRAME_WORDS, wr_count);
      check_equal("fifo_overflow", 1, fifo_overflow);

      $display("Error counts: %0d value mismatches, %0d other failures", err_value, err_other);
      if (err_value + err_other == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
verilog/cam_timing_pkg.sv
verilog/fifo_word_pkg.sv
verilog/cam_sync_capture.sv
verilog/line_frame_counter.sv
verilog/lock_fsm.sv
verilog/pixel_packer.sv
verilog/cam_if_to_fifo.sv
tests/tb_cam_if_to_fifo.sv

/* verilog/cam_if_to_fifo.sv */
/* Single clock design, cam_en must already be synchronous to CAM_pclk_in. A word reaches
   the FIFO port two clocks after its odd subpixel is sampled, once the frame is locked. */

`timescale 1ns/1ps

module cam_if_to_fifo
   import cam_timing_pkg::*;
   import fifo_word_pkg::*;
#(
   parameter int IMG_HSIZE    = 1920,
   parameter int IMG_VSIZE    = 1080,
   parameter int FIFO_CREDITS = 16
) (
   input  logic                 CAM_pclk_in,
   input  logic                 rst,
   // Camera port
   input  logic [CAM_BIT_W-1:0] cam_data,
   input  logic                 cam_hsync,
   input  logic                 cam_vsync,
   input  logic                 cam_de,
   input  logic                 cam_en,
   // Lock status
   output logic                 hsync_lock,
   output logic                 frame_lock,
   // FIFO port
   output logic                 fifo_wr_en,
   output pixel_word_u          fifo_wr_data,
   input  logic                 fifo_credit,
   output logic                 fifo_overflow
);

   cam_sample_t  sample;
   sync_events_t events;
   coord_t       sub_count;
   coord_t       line_count;

   cam_sync_capture u_capture (
      .CAM_pclk_in (CAM_pclk_in),
      .rst         (rst),
      .cam_data    (cam_data),
      .cam_hsync   (cam_hsync),
      .cam_vsync   (cam_vsync),
      .cam_de      (cam_de),
      .sample      (sample),
      .events      (events)
   );

   line_frame_counter #(
      .IMG_HSIZE (IMG_HSIZE)
   ) u_counter (
      .CAM_pclk_in (CAM_pclk_in),
      .rst         (rst),
      .sample      (sample),
      .events      (events),
      .sub_count   (sub_count),
      .line_count  (line_count)
   );

   lock_fsm #(
      .IMG_HSIZE (IMG_HSIZE),
      .IMG_VSIZE (IMG_VSIZE)
   ) u_lock (
      .CAM_pclk_in (CAM_pclk_in),
      .rst         (rst),
      .events      (events),
      .vsync       (sample.vsync),
      .sub_count   (sub_count),
      .line_count  (line_count),
      .cam_en      (cam_en),
      .hsync_lock  (hsync_lock),
      .frame_lock  (frame_lock)
   );

   pixel_packer #(
      .FIFO_CREDITS (FIFO_CREDITS)
   ) u_packer (
      .CAM_pclk_in   (CAM_pclk_in),
      .rst           (rst),
      .sample        (sample),
      .sub_count     (sub_count),
      .frame_lock    (frame_lock),
      .cam_en        (cam_en),
      .fifo_credit   (fifo_credit),
      .fifo_wr_en    (fifo_wr_en),
      .fifo_wr_data  (fifo_wr_data),
      .fifo_overflow (fifo_overflow)
   );

endmodule

/* verilog/cam_sync_capture.sv */
/* Inputs must already be in the CAM_pclk_in domain. Edge events come out two
   clocks after the port level falls. */

`timescale 1ns/1ps

module cam_sync_capture
   import cam_timing_pkg::*;
(
   input  logic                 CAM_pclk_in,
   input  logic                 rst,
   input  logic [CAM_BIT_W-1:0] cam_data,
   input  logic                 cam_hsync,
   input  logic                 cam_vsync,
   input  logic                 cam_de,
   output cam_sample_t          sample,
   output sync_events_t         events
);

   // Delayed copies of the registered sync levels
   logic hsync_d;
   logic vsync_d;
   logic de_d;

   // Input register stage
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         sample <= '0;
      end else begin
         sample.data  <= cam_data;
         sample.hsync <= cam_hsync;
         sample.vsync <= cam_vsync;
         sample.de    <= cam_de;
      end
   end

   // Previous level of each sync line
   // Held high in reset so release cannot look like a falling edge
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         hsync_d <= 1'b1;
         vsync_d <= 1'b1;
         de_d    <= 1'b1;
      end else begin
         hsync_d <= sample.hsync;
         vsync_d <= sample.vsync;
         de_d    <= sample.de;
      end
   end

   // Falling edge pulses, registered
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         events <= '0;
      end else begin
         events.hsync_end <= hsync_d & ~sample.hsync;
         events.vsync_end <= vsync_d & ~sample.vsync;
         events.de_end    <= de_d & ~sample.de;
      end
   end

endmodule

/* verilog/cam_timing_pkg.sv */
/* Camera side types. Counters are COORD_W bits wide, so a line can hold at most 8191
   subpixels. Every pixel arrives as two CAM_BIT_W-bit subpixels. */

package cam_timing_pkg;

   // Width of the subpixel and line counters
   localparam int COORD_W = 13;

   // Raw camera sample width
   localparam int CAM_BIT_W = 10;

   // Subpixel or line coordinate
   typedef logic [COORD_W-1:0] coord_t;

   // Registered camera inputs for one pixel clock
   typedef struct packed {
      logic [CAM_BIT_W-1:0] data;
      logic                 hsync;
      logic                 vsync;
      logic                 de;
   } cam_sample_t;

   // One-cycle falling edge pulses
   // Each fires one clock after the registered level drops
   typedef struct packed {
      logic hsync_end;
      logic vsync_end;
      logic de_end;
   } sync_events_t;

   // Lock tracking
   // LINE_FAULT means a bad line or a disable was seen in the current frame
   typedef enum logic [1:0] {
      NO_LOCK    = 2'd0,
      LOCKED     = 2'd1,
      LINE_FAULT = 2'd2
   } frame_state_t;

endpackage

/* verilog/fifo_word_pkg.sv */
/* FIFO side types. One FIFO word holds two 8-bit subpixels with the even one on top.
   The credit count is 8 bits wide, so FIFO depth is limited to 255 entries. */

package fifo_word_pkg;

   // Two packed subpixel bytes
   // even_byte lands in bits 15:8
   typedef struct packed {
      logic [7:0] even_byte;
      logic [7:0] odd_byte;
   } pixel_bytes_t;

   // Same 16 bits seen two ways
   // Packer fills the bytes, FIFO port carries the word
   typedef union packed {
      logic [15:0]  word;
      pixel_bytes_t bytes;
   } pixel_word_u;

   // Free FIFO entries held by the writer
   typedef logic [7:0] credit_t;

endpackage

/* verilog/line_frame_counter.sv */
/* Counts subpixels only while vsync and de are both high, two per pixel.
   The line count is held at zero between frames. */

`timescale 1ns/1ps

module line_frame_counter
   import cam_timing_pkg::*;
#(
   parameter int IMG_HSIZE = 1920
) (
   input  logic         CAM_pclk_in,
   input  logic         rst,
   input  cam_sample_t  sample,
   input  sync_events_t events,
   output coord_t       sub_count,
   output coord_t       line_count
);

   // Longest line the counter is expected to see
   // A few counts past a full line are allowed before the check flags a runaway
   localparam int SUB_MARGIN = COORD_W;
   localparam int SUB_LIMIT  = 2 * IMG_HSIZE + SUB_MARGIN;

   // Subpixel position within the current line
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         sub_count <= '0;
      end else if (sample.vsync && sample.de) begin
         sub_count <= sub_count + coord_t'(1);
      end else if (events.hsync_end) begin
         // Ready for the next de burst
         sub_count <= '0;
      end
   end

   // Completed lines within the current frame
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         line_count <= '0;
      end else if (events.de_end && sample.vsync) begin
         line_count <= line_count + coord_t'(1);
      end else if (!sample.vsync) begin
         line_count <= '0;
      end
   end

   // hsync_end must keep clearing the count inside a frame
   a_sub_count_bound : assert property (
      @(posedge CAM_pclk_in) disable iff (rst)
      sample.vsync |-> (int'(sub_count) <= SUB_LIMIT)
   );

endmodule

/* verilog/lock_fsm.sv */
/* A frame locks only if every line had exactly 2*IMG_HSIZE subpixels, IMG_VSIZE lines
   came in and cam_en stayed high. Lock is decided at each frame end. */

`timescale 1ns/1ps

module lock_fsm
   import cam_timing_pkg::*;
#(
   parameter int IMG_HSIZE = 1920,
   parameter int IMG_VSIZE = 1080
) (
   input  logic         CAM_pclk_in,
   input  logic         rst,
   input  sync_events_t events,
   input  logic         vsync,
   input  coord_t       sub_count,
   input  coord_t       line_count,
   input  logic         cam_en,
   output logic         hsync_lock,
   output logic         frame_lock
);

   localparam coord_t LINE_SUBPIX = coord_t'(2 * IMG_HSIZE);
   localparam coord_t FRAME_LINES = coord_t'(IMG_VSIZE);

   frame_state_t state;
   frame_state_t state_next;

   // Line count match, sampled while vsync is high
   // The counter clears before vsync_end arrives, so the result is held here
   logic lines_ok;

   // Line end with the wrong subpixel count inside a frame
   logic line_bad;

   assign line_bad = events.hsync_end && vsync && (sub_count != LINE_SUBPIX);

   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         lines_ok <= 1'b0;
      end else if (vsync) begin
         lines_ok <= (line_count == FRAME_LINES);
      end
   end

   // Next state
   // Frame end wins over a fault in the same cycle
   always_comb begin
      state_next = state;
      if (events.vsync_end) begin
         if ((state != LINE_FAULT) && lines_ok) begin
            state_next = LOCKED;
         end else begin
            state_next = NO_LOCK;
         end
      end else if (!cam_en || line_bad) begin
         state_next = LINE_FAULT;
      end
   end

   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         state <= NO_LOCK;
      end else begin
         state <= state_next;
      end
   end

   // Line check flag
   // Re-armed at every frame end, dropped by a bad line or a disable
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         hsync_lock <= 1'b0;
      end else if (events.vsync_end) begin
         hsync_lock <= 1'b1;
      end else if (!cam_en || line_bad) begin
         hsync_lock <= 1'b0;
      end
   end

   assign frame_lock = (state == LOCKED);

   // Lock is only ever granted at a frame boundary
   a_lock_at_frame_end : assert property (
      @(posedge CAM_pclk_in) disable iff (rst)
      $rose(frame_lock) |-> $past(events.vsync_end)
   );

endmodule

/* verilog/pixel_packer.sv */
/* The camera cannot be stalled, so a finished word with no credit is lost and sets a
   sticky overflow. FIFO_CREDITS must match the FIFO depth and stay below 256. */

`timescale 1ns/1ps

module pixel_packer
   import cam_timing_pkg::*;
   import fifo_word_pkg::*;
#(
   parameter int FIFO_CREDITS = 16
) (
   input  logic        CAM_pclk_in,
   input  logic        rst,
   input  cam_sample_t sample,
   input  coord_t      sub_count,
   input  logic        frame_lock,
   input  logic        cam_en,
   input  logic        fifo_credit,
   output logic        fifo_wr_en,
   output pixel_word_u fifo_wr_data,
   output logic        fifo_overflow
);

   localparam credit_t FULL_CREDITS = credit_t'(FIFO_CREDITS);

   // Word being assembled and its completion flag
   pixel_word_u pack_word;
   logic        word_done;

   // Free FIFO entries
   credit_t credits;

   // Write decision for the finished word
   logic wr_allowed;
   logic wr_go;
   logic wr_drop;

   // Stage one, byte packing
   // sub_count bit 0 tells even from odd, the first subpixel of a line is even
   always_ff @(posedge CAM_pclk_in) begin
      if (sample.vsync && sample.de) begin
         if (sub_count[0]) begin
            pack_word.bytes.odd_byte <= sample.data[CAM_BIT_W-1 -: 8];
         end else begin
            pack_word.bytes.even_byte <= sample.data[CAM_BIT_W-1 -: 8];
         end
      end
   end

   // Complete after the odd byte, only inside a de burst
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         word_done <= 1'b0;
      end else begin
         word_done <= sample.vsync && sample.de && sub_count[0];
      end
   end

   assign wr_allowed = word_done && frame_lock && cam_en;
   assign wr_go      = wr_allowed && (credits != '0);
   assign wr_drop    = wr_allowed && (credits == '0);

   // Stage two, FIFO write port
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         fifo_wr_en <= 1'b0;
      end else begin
         fifo_wr_en <= wr_go;
      end
   end

   always_ff @(posedge CAM_pclk_in) begin
      fifo_wr_data <= pack_word;
   end

   // Credit count
   // Spent when the write is issued, returned one per freed entry
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         credits <= FULL_CREDITS;
      end else begin
         case ({wr_go, fifo_credit})
            2'b10:   credits <= credits - credit_t'(1);
            2'b01:   credits <= credits + credit_t'(1);
            default: credits <= credits;
         endcase
      end
   end

   // Sticky until reset
   always_ff @(posedge CAM_pclk_in) begin
      if (rst) begin
         fifo_overflow <= 1'b0;
      end else if (wr_drop) begin
         fifo_overflow <= 1'b1;
      end
   end

   // Each write strobe must have been backed by a credit
   a_write_has_credit : assert property (
      @(posedge CAM_pclk_in) disable iff (rst)
      fifo_wr_en |-> ($past(credits) != '0)
   );

   // The FIFO never returns more entries than it has
   a_credit_bound : assert property (
      @(posedge CAM_pclk_in) disable iff (rst)
      credits <= FULL_CREDITS
   );

endmodule
